// ==== ccir656_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ntsc_defines.svh"

module ccir656_decoder
   import ntsc_pkg::*;
(
   input  wire                     clk,
   input  wire                     reset,
   input  wire [`NTSC_WORD_W-1:0]  i_word,
   video_if.decoder                o_vid
);

   decode_state_t state_q;
   decode_state_t act_next;
   // Set while SYNC_3 waits for the code word itself
   logic          code_phase_q;
   logic          is_ff;
   logic          is_00;
   logic          is_sav;
   logic          is_code;
   logic          is_luma;

   assign is_ff  = (i_word == `NTSC_CODE_FF);
   assign is_00  = (i_word == `NTSC_CODE_00);
   // Start of active video: bit 9 set, v and h clear
   assign is_sav = i_word[9] && !i_word[`NTSC_BIT_V] && !i_word[`NTSC_BIT_H];

   assign is_code = (state_q == SYNC_3) && code_phase_q;
   assign is_luma = ((state_q == ACT_Y0) || (state_q == ACT_Y1)) && !is_ff;

   // Cb Y0 Cr Y1 repeats until the next preamble
   always_comb
   begin
      case (state_q)
         ACT_CB:  act_next = ACT_Y0;
         ACT_Y0:  act_next = ACT_CR;
         ACT_CR:  act_next = ACT_Y1;
         default: act_next = ACT_CB;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////
   // Word stream FSM
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state_q      <= SYNC_1;
         code_phase_q <= 1'b0;
      end
      else
      begin
         code_phase_q <= 1'b0;
         case (state_q)
            SYNC_1:
            begin
               // Hunt for the 3FF preamble word
               if (is_ff)
                  state_q <= SYNC_2;
            end
            SYNC_2:
            begin
               if (is_00)
                  state_q <= SYNC_3;
               else if (!is_ff)
                  state_q <= SYNC_1;
            end
            SYNC_3:
            begin
               if (code_phase_q)
                  state_q <= is_sav ? ACT_CB : SYNC_1;
               else if (is_00)
                  code_phase_q <= 1'b1;
               else if (is_ff)
                  state_q <= SYNC_2;
               else
                  state_q <= SYNC_1;
            end
            default:
            begin
               // Any 3FF inside active video opens a new preamble
               if (is_ff)
                  state_q <= SYNC_2;
               else
                  state_q <= act_next;
            end
         endcase
      end
   end

   // Strobes, one cycle after the word
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         o_vid.pix_valid  <= 1'b0;
         o_vid.code_valid <= 1'b0;
      end
      else
      begin
         o_vid.pix_valid  <= is_luma;
         o_vid.code_valid <= is_code;
      end
   end

   // Component and code bit capture
   always_ff @(posedge clk)
   begin
      if (is_luma)
         o_vid.y <= i_word;
      if ((state_q == ACT_CB) && !is_ff)
         o_vid.cb <= i_word;
      if ((state_q == ACT_CR) && !is_ff)
         o_vid.cr <= i_word;
      if (is_code)
      begin
         o_vid.f <= i_word[`NTSC_BIT_F];
         o_vid.v <= i_word[`NTSC_BIT_V];
         o_vid.h <= i_word[`NTSC_BIT_H];
      end
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
ntsc_pkg.sv
video_if.sv
ccir656_decoder.sv
raster_tracker.sv
detection_builder.sv
record_fifo.sv
record_sender.sv
ntsc_capture.sv
tb_ntsc_capture.sv

// ==== detection_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ntsc_defines.svh"

module detection_builder
   import ntsc_pkg::*;
(
   input  wire          clk,
   input  wire          reset,
   video_if.consumer    i_vid,
   raster_if.builder    i_ras,
   output detect_rec_t  o_rec,
   output logic         o_rec_valid
);

   logic   is_orange;
   logic   is_green;
   logic   is_pink;
   logic   is_blue;
   logic   is_hit;
   color_t color_hit;

   ////////////////////////////////////////////////////////////////////////
   // Threshold tests
   ////////////////////////////////////////////////////////////////////////

   assign is_orange = (i_vid.cb < `ORANGE_CB_MAX) && (i_vid.cr > `ORANGE_CR_MIN)
                      && (i_vid.y > `ORANGE_LUM_MIN);
   assign is_green  = (i_vid.y > `GREEN_LUM_MIN) && (i_vid.y < `GREEN_LUM_MAX)
                      && (i_vid.cr > `GREEN_CR_MIN) && (i_vid.cr < `GREEN_CR_MAX)
                      && (i_vid.cb > `GREEN_CB_MIN) && (i_vid.cb < `GREEN_CB_MAX);
   assign is_pink   = (i_vid.cb > `PINK_CB_MIN) && (i_vid.cr > `PINK_CR_MIN)
                      && (i_vid.y > `PINK_LUM_MIN);
   assign is_blue   = (i_vid.cb > `BLUE_CB_MIN) && (i_vid.cr < `BLUE_CR_MAX)
                      && (i_vid.y > `BLUE_LUM_MIN);

   // Priority orange, green, pink, blue
   always_comb
   begin
      is_hit    = 1'b1;
      color_hit = COLOR_ORANGE;
      if (is_orange)
         color_hit = COLOR_ORANGE;
      else if (is_green)
         color_hit = COLOR_GREEN;
      else if (is_pink)
         color_hit = COLOR_PINK;
      else if (is_blue)
         color_hit = COLOR_BLUE;
      else
         is_hit = 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         o_rec_valid <= 1'b0;
      else
         o_rec_valid <= i_ras.frame_start || (i_vid.pix_valid && i_ras.active && is_hit);
   end

   // Frame and pixel records never share a cycle, frame wins anyway
   always_ff @(posedge clk)
   begin
      if (i_ras.frame_start)
         o_rec <= '{kind: REC_FRAME, color: COLOR_ORANGE, x: '0, line: '0};
      else
         o_rec <= '{kind: REC_PIXEL, color: color_hit, x: i_ras.x, line: i_ras.line};
   end

endmodule

`default_nettype wire

// ==== ntsc_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ntsc_defines.svh"

module ntsc_capture
   import ntsc_pkg::*;
(
   input  wire                     clk,
   input  wire                     reset,
   input  wire [`NTSC_WORD_W-1:0]  i_video_data,
   output logic                    o_req,
   input  wire                     i_ack,
   output logic                    o_rec_kind,
   output logic [1:0]              o_color,
   output logic [`NTSC_X_W-1:0]    o_x,
   output logic [`NTSC_Y_W-1:0]    o_y,
   output logic                    o_overflow
);

   video_if  u_vid ();
   raster_if u_ras ();

   detect_rec_t build_rec;
   logic        build_valid;
   detect_rec_t fifo_head;
   logic        fifo_empty;
   logic        fifo_pop;
   detect_rec_t send_rec;

   ////////////////////////////////////////////////////////////////////////
   // Stream decode, raster position, detection
   ////////////////////////////////////////////////////////////////////////

   ccir656_decoder u_decoder (
      .clk    (clk),
      .reset  (reset),
      .i_word (i_video_data),
      .o_vid  (u_vid.decoder)
   );

   raster_tracker u_tracker (
      .clk   (clk),
      .reset (reset),
      .i_vid (u_vid.consumer),
      .o_ras (u_ras.tracker)
   );

   detection_builder u_builder (
      .clk         (clk),
      .reset       (reset),
      .i_vid       (u_vid.consumer),
      .i_ras       (u_ras.builder),
      .o_rec       (build_rec),
      .o_rec_valid (build_valid)
   );

   // Queue and req/ack output
   record_fifo u_fifo (
      .clk        (clk),
      .reset      (reset),
      .i_rec      (build_rec),
      .i_wr       (build_valid),
      .o_head     (fifo_head),
      .o_empty    (fifo_empty),
      .i_pop      (fifo_pop),
      .o_overflow (o_overflow)
   );

   record_sender u_sender (
      .clk     (clk),
      .reset   (reset),
      .i_head  (fifo_head),
      .i_empty (fifo_empty),
      .o_pop   (fifo_pop),
      .o_req   (o_req),
      .o_rec   (send_rec),
      .i_ack   (i_ack)
   );

   // Record fields onto the pins
   assign o_rec_kind = send_rec.kind;
   assign o_color    = send_rec.color;
   assign o_x        = send_rec.x;
   assign o_y        = send_rec.line;

endmodule

`default_nettype wire

// ==== ntsc_defines.svh ====
`ifndef NTSC_DEFINES_SVH
`define NTSC_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Stream and raster geometry
////////////////////////////////////////////////////////////////////////////

// One CCIR656 word per clock, each component uses the full word
`define NTSC_WORD_W      10
`define NTSC_X_W         10
`define NTSC_Y_W         9

// Active window inside the interlaced line numbering
`define NTSC_ACTIVE_W    640
`define NTSC_Y_TOP       25
`define NTSC_ACTIVE_H    480

// Record queue between detection and the req/ack port
`define NTSC_FIFO_DEPTH  16

// Preamble words and the f/v/h positions inside the reference code
`define NTSC_CODE_FF     10'h3FF
`define NTSC_CODE_00     10'h000
`define NTSC_BIT_F       8
`define NTSC_BIT_V       7
`define NTSC_BIT_H       6

////////////////////////////////////////////////////////////////////////////
// Colour thresholds on 10-bit Y, Cr, Cb (all strict compares)
////////////////////////////////////////////////////////////////////////////

`define ORANGE_CB_MAX    10'd400
`define ORANGE_CR_MIN    10'd640
`define ORANGE_LUM_MIN   10'd300
`define GREEN_LUM_MIN    10'd200
`define GREEN_LUM_MAX    10'd600
`define GREEN_CR_MIN     10'd300
`define GREEN_CR_MAX     10'd480
`define GREEN_CB_MIN     10'd300
`define GREEN_CB_MAX     10'd480
`define PINK_CB_MIN      10'd560
`define PINK_CR_MIN      10'd600
`define PINK_LUM_MIN     10'd400
`define BLUE_CB_MIN      10'd640
`define BLUE_CR_MAX      10'd440
`define BLUE_LUM_MIN     10'd160

`endif

// ==== ntsc_pkg.sv ====
`default_nettype none

`include "ntsc_defines.svh"

package ntsc_pkg;

   // Decoder walk through preamble, then the Cb Y Cr Y pixel cycle
   typedef enum logic [2:0] {
      SYNC_1,
      SYNC_2,
      SYNC_3,
      ACT_CB,
      ACT_Y0,
      ACT_CR,
      ACT_Y1
   } decode_state_t;

   // Colour codes as carried on o_color
   typedef enum logic [1:0] {
      COLOR_ORANGE = 2'd0,
      COLOR_PINK   = 2'd1,
      COLOR_BLUE   = 2'd2,
      COLOR_GREEN  = 2'd3
   } color_t;

   typedef enum logic {
      REC_FRAME = 1'b0,
      REC_PIXEL = 1'b1
   } rec_kind_t;

   // Output handshake machine
   typedef enum logic [1:0] {
      SEND_IDLE,
      SEND_REQ,
      SEND_WAIT_LOW
   } send_state_t;

   // One queued detection, 22 bits
   typedef struct packed {
      rec_kind_t                 kind;
      color_t                    color;
      logic [`NTSC_X_W-1:0]      x;
      logic [`NTSC_Y_W-1:0]      line;
   } detect_rec_t;

endpackage

`default_nettype wire

// ==== raster_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ntsc_defines.svh"

module raster_tracker (
   input  wire          clk,
   input  wire          reset,
   video_if.consumer    i_vid,
   raster_if.tracker    o_ras
);

   // One extra bit so a full field never wraps back into the window
   localparam int LINE_W = `NTSC_Y_W + 1;
   localparam logic [LINE_W-1:0] LINE_TOP = LINE_W'(`NTSC_Y_TOP);
   localparam logic [LINE_W-1:0] LINE_END = LINE_W'(`NTSC_Y_TOP + `NTSC_ACTIVE_H);

   logic [LINE_W-1:0]     line_idx_q;
   logic [LINE_W-1:0]     line_rel;
   logic [`NTSC_X_W-1:0]  x_q;
   logic                  seen_f0_q;
   logic                  code_vbl;
   logic                  code_eav;
   logic                  code_sav;
   logic                  frame_pulse;

   assign code_vbl = i_vid.code_valid && i_vid.v;
   assign code_eav = i_vid.code_valid && i_vid.h && !i_vid.v;
   assign code_sav = i_vid.code_valid && !i_vid.h && !i_vid.v;

   // First blanking code of field 1 after field 0 was seen
   assign frame_pulse = code_vbl && i_vid.f && seen_f0_q;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         line_idx_q <= '0;
         x_q        <= '0;
         seen_f0_q  <= 1'b0;
      end
      else
      begin
         // Interlaced numbering, each field steps by two
         if (code_vbl)
            line_idx_q <= {{(LINE_W-1){1'b0}}, i_vid.f};
         else if (code_eav)
            line_idx_q <= line_idx_q + 2'd2;
         // x holds at its top value on an overlong line
         if (code_sav)
            x_q <= '0;
         else if (i_vid.pix_valid && (x_q != '1))
            x_q <= x_q + 1'b1;
         if (frame_pulse)
            seen_f0_q <= 1'b0;
         else if (i_vid.code_valid && !i_vid.f)
            seen_f0_q <= 1'b1;
      end
   end

   assign line_rel = line_idx_q - LINE_TOP;

   assign o_ras.active      = (line_idx_q >= LINE_TOP) && (line_idx_q < LINE_END)
                              && (x_q < `NTSC_ACTIVE_W);
   assign o_ras.x           = x_q;
   assign o_ras.line        = line_rel[`NTSC_Y_W-1:0];
   assign o_ras.frame_start = frame_pulse;

endmodule

`default_nettype wire

// ==== record_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ntsc_defines.svh"

module record_fifo
   import ntsc_pkg::*;
(
   input  wire               clk,
   input  wire               reset,
   input  wire detect_rec_t  i_rec,
   input  wire               i_wr,
   output detect_rec_t       o_head,
   output logic              o_empty,
   input  wire               i_pop,
   output logic              o_overflow
);

   localparam int PTR_W = $clog2(`NTSC_FIFO_DEPTH);
   localparam logic [PTR_W:0] FULL_COUNT = (PTR_W+1)'(`NTSC_FIFO_DEPTH);

   detect_rec_t        mem [`NTSC_FIFO_DEPTH];
   logic [PTR_W-1:0]   wr_ptr_q;
   logic [PTR_W-1:0]   rd_ptr_q;
   logic [PTR_W:0]     count_q;
   logic               full;
   logic               do_wr;
   logic               do_rd;

   assign full  = (count_q == FULL_COUNT);
   // A write into a full queue is lost
   assign do_wr = i_wr && !full;
   assign do_rd = i_pop && !o_empty;

   // Storage array
   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr_q] <= i_rec;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         o_overflow <= 1'b0;
      end
      else
      begin
         if (do_wr)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_rd)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (do_wr && !do_rd)
            count_q <= count_q + 1'b1;
         else if (do_rd && !do_wr)
            count_q <= count_q - 1'b1;
         // Sticky until reset
         if (i_wr && full)
            o_overflow <= 1'b1;
      end
   end

   assign o_head  = mem[rd_ptr_q];
   assign o_empty = (count_q == '0);

endmodule

`default_nettype wire

// ==== record_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

module record_sender
   import ntsc_pkg::*;
(
   input  wire               clk,
   input  wire               reset,
   input  wire detect_rec_t  i_head,
   input  wire               i_empty,
   output logic              o_pop,
   output logic              o_req,
   output detect_rec_t       o_rec,
   input  wire               i_ack
);

   send_state_t state_q;

   always_ff @(posedge clk)
   begin
      if (reset)
         state_q <= SEND_IDLE;
      else
      begin
         case (state_q)
            SEND_IDLE:
            begin
               if (!i_empty)
                  state_q <= SEND_REQ;
            end
            SEND_REQ:
            begin
               if (i_ack)
                  state_q <= SEND_WAIT_LOW;
            end
            default:
            begin
               // Four-phase, ack must drop before the next req
               if (!i_ack)
                  state_q <= SEND_IDLE;
            end
         endcase
      end
   end

   // Head is held on the output for the whole req phase
   always_ff @(posedge clk)
   begin
      if ((state_q == SEND_IDLE) && !i_empty)
         o_rec <= i_head;
   end

   assign o_req = (state_q == SEND_REQ);
   // Pop on the same edge that drops req
   assign o_pop = (state_q == SEND_REQ) && i_ack;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_ntsc_capture \
   -o tb_ntsc_capture > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see build.log"
   exit 1
fi

./obj_dir/tb_ntsc_capture > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "Simulation exited with an error, see sim.log"
   exit 1
fi

if grep -q "Something failed" sim.log; then
   echo "Simulation reported failure, see sim.log"
   exit 1
fi

echo "Simulation passed"
exit 0

// ==== tb_ntsc_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ntsc_defines.svh"

module tb_ntsc_capture
   import ntsc_pkg::*;
();

   logic                     clk = 1'b0;
   logic                     reset;
   logic [`NTSC_WORD_W-1:0]  video_data;
   logic                     ack;
   logic                     req;
   logic                     rec_kind;
   logic [1:0]               color;
   logic [`NTSC_X_W-1:0]     x;
   logic [`NTSC_Y_W-1:0]     y;
   logic                     overflow;

   integer      seed;
   int          cycle_cnt = 0;
   int          content_words = 0;
   int          exp_total = 0;
   int          mismatches = 0;
   int          other_errs = 0;
   int          delivered = 0;
   bit          hold_ack = 1'b0;
   // Set once records may be dropped by the full queue
   bit          lossy = 1'b0;
   bit          field_f = 1'b0;

   // Model of the raster and component state
   logic [9:0]  cur_cb;
   logic [9:0]  cur_cr;
   int          line_idx = 0;
   int          x_cnt = 0;
   bit          seen_f0 = 1'b0;
   logic [21:0] exp_q[$];

   ntsc_capture u_dut (
      .clk          (clk),
      .reset        (reset),
      .i_video_data (video_data),
      .o_req        (req),
      .i_ack        (ack),
      .o_rec_kind   (rec_kind),
      .o_color      (color),
      .o_x          (x),
      .o_y          (y),
      .o_overflow   (overflow)
   );

   always #20 clk = ~clk;

   // Cycle limit grows with stream words and expected records
   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > content_words + 20 * exp_total + 400)
      begin
         $display("Timeout: DUT stopped raising req before the cycle limit %0d", cycle_cnt);
         $display("Something failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         mismatches++;
         $display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   function automatic int rand_range(input int n);
      return ($random(seed) & 32'h7fff_ffff) % n;
   endfunction

   // Component values clustered around the colour thresholds
   function automatic logic [9:0] pick_comp();
      case (rand_range(16))
         0:       return 10'd150;
         1:       return 10'd170;
         2:       return 10'd250;
         3:       return 10'd310;
         4:       return 10'd350;
         5:       return 10'd390;
         6:       return 10'd410;
         7:       return 10'd450;
         8:       return 10'd470;
         9:       return 10'd500;
         10:      return 10'd570;
         11:      return 10'd610;
         12:      return 10'd650;
         13:      return 10'd700;
         14:      return 10'd900;
         default: return 10'(rand_range(1022) + 1);
      endcase
   endfunction

   // Hit flag and colour, first match in orange green pink blue order
   function automatic logic [2:0] classify(input logic [9:0] py, input logic [9:0] pcb,
                                           input logic [9:0] pcr);
      if (pcb < `ORANGE_CB_MAX && pcr > `ORANGE_CR_MIN && py > `ORANGE_LUM_MIN)
         return {1'b1, COLOR_ORANGE};
      if (py > `GREEN_LUM_MIN && py < `GREEN_LUM_MAX && pcr > `GREEN_CR_MIN
          && pcr < `GREEN_CR_MAX && pcb > `GREEN_CB_MIN && pcb < `GREEN_CB_MAX)
         return {1'b1, COLOR_GREEN};
      if (pcb > `PINK_CB_MIN && pcr > `PINK_CR_MIN && py > `PINK_LUM_MIN)
         return {1'b1, COLOR_PINK};
      if (pcb > `BLUE_CB_MIN && pcr < `BLUE_CR_MAX && py > `BLUE_LUM_MIN)
         return {1'b1, COLOR_BLUE};
      return 3'b000;
   endfunction

   task automatic push_exp(input logic [21:0] rec);
      exp_q.push_back(rec);
      exp_total++;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stream generator with the model alongside
   ////////////////////////////////////////////////////////////////////////////

   task automatic put_word(input logic [9:0] w);
      @(negedge clk);
      video_data = w;
      content_words++;
   endtask

   // Filler between lines, decoder is out of active video here
   task automatic put_idle();
      @(negedge clk);
      video_data = 10'h200;
   endtask

   task automatic put_code(input bit f, input bit v, input bit h);
      put_word(`NTSC_CODE_FF);
      put_word(`NTSC_CODE_00);
      put_word(`NTSC_CODE_00);
      put_word({1'b1, f, v, h, 6'b0});
      if (v)
         line_idx = int'(f);
      else if (h)
         line_idx = line_idx + 2;
      if (!v && !h)
         x_cnt = 0;
      // Frame start on f=1 blanking code after any f=0 code
      if (v && f && seen_f0)
      begin
         push_exp({REC_FRAME, COLOR_ORANGE, 10'd0, 9'd0});
         seen_f0 = 1'b0;
      end
      else if (!f)
         seen_f0 = 1'b1;
   endtask

   task automatic model_pixel(input logic [9:0] py);
      logic [2:0] c;
      c = classify(py, cur_cb, cur_cr);
      if (line_idx >= `NTSC_Y_TOP && line_idx < `NTSC_Y_TOP + `NTSC_ACTIVE_H
          && x_cnt < `NTSC_ACTIVE_W && c[2])
         push_exp({REC_PIXEL, c[1:0], 10'(x_cnt), 9'(line_idx - `NTSC_Y_TOP)});
      x_cnt++;
   endtask

   // Cb Y0 Cr Y1, Y0 still pairs with the previous Cr
   task automatic put_group();
      logic [9:0] w;
      w = pick_comp();
      put_word(w);
      cur_cb = w;
      w = pick_comp();
      put_word(w);
      model_pixel(w);
      w = pick_comp();
      put_word(w);
      cur_cr = w;
      w = pick_comp();
      put_word(w);
      model_pixel(w);
   endtask

   task automatic gen_line(input bit glitch);
      int n;
      int k;
      bit broken;
      broken = 1'b0;
      put_code(field_f, 1'b0, 1'b1);
      // Keep the queue shallow while exact order is checked
      if (!lossy)
         while (exp_q.size() > 2)
            put_idle();
      put_code(field_f, 1'b0, 1'b0);
      n = 1 + rand_range(5);
      for (int i = 0; i < n; i++)
      begin
         if (!broken)
         begin
            put_group();
            if (glitch && i == n / 2)
            begin
               // Stray preamble then pixel-like junk, none of it counts
               put_word(`NTSC_CODE_FF);
               k = 3 + rand_range(4);
               repeat (k)
                  put_word(pick_comp());
               broken = 1'b1;
            end
         end
      end
   endtask

   task automatic gen_field();
      put_code(field_f, 1'b1, 1'b1);
      for (int l = 0; l < 16; l++)
         gen_line(rand_range(6) == 0);
      field_f = !field_f;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Ack responder and record checker
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin : responder
      logic [21:0] got;
      int          d;
      ack = 1'b0;
      forever
      begin
         @(negedge clk);
         if (req && !hold_ack)
         begin
            got = {rec_kind, color, x, y};
            d = rand_range(7);
            repeat (d)
            begin
               @(negedge clk);
               check_equal("req held until ack", 32'(req), 32'd1);
               check_equal("record stable during req", 32'({rec_kind, color, x, y}),
                           32'(got));
            end
            ack = 1'b1;
            delivered++;
            if (!lossy)
            begin
               if (exp_q.size() == 0)
               begin
                  other_errs++;
                  $display("Record %h delivered while the model expected none", got);
               end
               else
                  check_equal("delivered record", 32'(got), 32'(exp_q.pop_front()));
            end
            else
            begin
               // After drops the output is an in-order subsequence
               while (exp_q.size() > 0 && exp_q[0] != got)
                  void'(exp_q.pop_front());
               if (exp_q.size() == 0)
               begin
                  other_errs++;
                  $display("Record %h is out of order or was never expected", got);
               end
               else
                  void'(exp_q.pop_front());
            end
            do
               @(negedge clk);
            while (req);
            // Ack lingers after req falls, the next req must wait for it
            d = rand_range(4);
            repeat (d)
            begin
               @(negedge clk);
               check_equal("req low while ack still high", 32'(req), 32'd0);
            end
            ack = 1'b0;
            @(negedge clk);
            check_equal("req low after ack release", 32'(req), 32'd0);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin : main
      int start;
      int quiet;
      int held_from;
      seed = 32'h019f_d4c9;
      video_data = 10'h200;
      reset = 1'b1;
      repeat (5)
         @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // Exact order with random ack delay
      repeat (4)
         gen_field();
      while (exp_q.size() > 0)
         put_idle();
      repeat (4)
         put_idle();
      check_equal("overflow before back-pressure", 32'(overflow), 32'd0);

      // Ack withheld until the queue overflows
      hold_ack = 1'b1;
      lossy = 1'b1;
      held_from = delivered;
      start = exp_total;
      while (exp_total - start < `NTSC_FIFO_DEPTH + 8)
         gen_field();
      repeat (10)
         put_idle();
      check_equal("overflow after held ack", 32'(overflow), 32'd1);
      hold_ack = 1'b0;

      quiet = 0;
      while (quiet < 60)
      begin
         put_idle();
         quiet = req ? 0 : quiet + 1;
      end
      check_equal("overflow stays sticky", 32'(overflow), 32'd1);
      // A full queue hands out exactly its depth once ack returns
      check_equal("records delivered after held ack", 32'(delivered - held_from),
                  32'(`NTSC_FIFO_DEPTH));

      $display("Checks done: %0d mismatches, %0d other errors, %0d records delivered",
               mismatches, other_errs, delivered);
      if (mismatches == 0 && other_errs == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== video_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ntsc_defines.svh"

// Decoded samples and reference codes
interface video_if;
   logic                     pix_valid;
   logic [`NTSC_WORD_W-1:0]  y;
   logic [`NTSC_WORD_W-1:0]  cr;
   logic [`NTSC_WORD_W-1:0]  cb;
   logic                     code_valid;
   logic                     f;
   logic                     v;
   logic                     h;

   modport decoder  (output pix_valid, y, cr, cb, code_valid, f, v, h);
   modport consumer (input  pix_valid, y, cr, cb, code_valid, f, v, h);
endinterface

// Position of the current pixel in the raster
interface raster_if;
   logic                     active;
   logic [`NTSC_X_W-1:0]     x;
   logic [`NTSC_Y_W-1:0]     line;
   logic                     frame_start;

   modport tracker (output active, x, line, frame_start);
   modport builder (input  active, x, line, frame_start);
endinterface

`default_nettype wire
